//--- test/pet_tests.txt
# kind addr data expect (hex). PW expect {cpu_ready_o,cpu_res_nao}, PR/CR expect read byte
# CW/CS expect active-low {ram_ce,ram_we,pia1_cs,pia2_cs,via_cs,io_oe}, CS is a CPU read
CS 0100 00 3F
CW 0200 77 3F
PR 0200 00 02
PW 0123 5A 0
PR 0123 00 5A
PW 1E000 33 0
PR 1E000 00 33
PR E000 00 E0
PW E80F 01 1
CS 0100 00 3F
PW E80F 03 3
PR E80F 00 03
CS 0100 00 1F
PW E803 A5 3
PW E800 7E 3
CW E810 03 36
CR E812 00 A5
CS E812 00 3F
CW E810 00 36
CR E812 00 7E
CW E810 0C 36
CR E812 00 FF
PW A000 11 3
CW A000 22 1F
PR A000 00 11
CW 0300 44 0F
PR 0300 00 44
PW 8C00 AA 3
PW 8000 55 3
CR 8C00 00 55
PR 8C00 00 AA
CW 8C10 66 0F
PR 8010 00 66
CS E820 00 3A
CS E840 00 3C
CS E810 00 36

//--- sources.f
src/pet_pkg.sv
src/bus_timing.sv
src/address_decoder.sv
src/keyboard_matrix.sv
src/pi_control.sv
src/bus_mux.sv
src/pet_main.sv
test/tb_pet_main.sv

//--- test/tb_pet_main.sv
//######################################################################
// Testbench for the PET bus controller
// Replays host and CPU transactions from the test file
// RAM model and result compare tasks
//######################################################################
`timescale 1ns/1ps

module tb_pet_main import pet_pkg::*; ();

    typedef struct packed {
        logic ram_ce_n;
        logic ram_we_n;                             // Low if seen anywhere in the window
        logic pia1_cs_n;
        logic pia2_cs_n;
        logic via_cs_n;
        logic io_oe_n;
    } cs_set_t;

    logic              clk_16;
    logic              arst_n;
    logic              pi_valid;
    pi_req_t           pi_req;
    logic              pi_done;
    logic [DATA_W-1:0] pi_rdata;
    logic              clk_cpu;
    logic              cpu_res_n;
    logic              cpu_ready;
    logic [15:0]       cpu_addr;
    logic [DATA_W-1:0] cpu_data;
    logic              cpu_rw_n;
    logic [DATA_W-1:0] cpu_rdata;
    logic [DATA_W-1:0] ram_data_in;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_data_out;
    logic              ram_ce_n;
    logic              ram_oe_n;
    logic              ram_we_n;
    logic              pia1_cs_n;
    logic              pia2_cs_n;
    logic              via_cs_n;
    logic              io_oe_n;
    logic [DATA_W-1:0] ram_mem [2**ADDR_W];         // Full 128K bus RAM

    pet_main u_pet_main (
        .clk_16_i    (clk_16),
        .arst_n_i    (arst_n),
        .pi_valid_i  (pi_valid),
        .pi_req_i    (pi_req),
        .pi_done_o   (pi_done),
        .pi_rdata_o  (pi_rdata),
        .clk_cpu_o   (clk_cpu),
        .cpu_res_nao (cpu_res_n),
        .cpu_ready_o (cpu_ready),
        .cpu_addr_i  (cpu_addr),
        .cpu_data_i  (cpu_data),
        .cpu_rw_n_i  (cpu_rw_n),
        .cpu_rdata_o (cpu_rdata),
        .ram_data_i  (ram_data_in),
        .ram_addr_o  (ram_addr),
        .ram_data_o  (ram_data_out),
        .ram_ce_no   (ram_ce_n),
        .ram_oe_no   (ram_oe_n),
        .ram_we_no   (ram_we_n),
        .pia1_cs_no  (pia1_cs_n),
        .pia2_cs_no  (pia2_cs_n),
        .via_cs_no   (via_cs_n),
        .io_oe_no    (io_oe_n)
    );

    initial begin
        clk_16 = 1'b0;
        forever #20 clk_16 = ~clk_16;               // 40 ns period
    end

    // Initial RAM contents, every address bit folded in
    function automatic logic [DATA_W-1:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'b0};
    endfunction

    initial begin
        for (int a = 0; a < 2**ADDR_W; a++) begin
            ram_mem[a] = fill_byte(a);
        end
    end

    // Async read, data undefined unless the RAM is selected and driving
    assign ram_data_in = (!ram_ce_n && !ram_oe_n) ? ram_mem[ram_addr] : 'x;

    always @(posedge clk_16) begin
        if (!ram_ce_n && !ram_we_n) begin
            ram_mem[ram_addr] <= ram_data_out;      // Write on the strobe
        end
    end

    // CPU view of VRAM is 1K mirrored over 8000-8FFF
    function automatic logic [ADDR_W-1:0] cpu_ram_addr(input logic [15:0] a);
        logic [ADDR_W-1:0] r;
        r = {1'b0, a};
        if (a >= VRAM_BASE && a <= VRAM_END) begin
            r[11:10] = 2'b00;
        end
        return r;
    endfunction

    function automatic cs_set_t sample_cs();
        cs_set_t s;
        s.ram_ce_n  = ram_ce_n;
        s.ram_we_n  = ram_we_n;
        s.pia1_cs_n = pia1_cs_n;
        s.pia2_cs_n = pia2_cs_n;
        s.via_cs_n  = via_cs_n;
        s.io_oe_n   = io_oe_n;
        return s;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_ctl(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_region(input string name, input cs_set_t got, input cs_set_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // Step falling edges until the CPU clock sits at the given level
    task automatic wait_cpu_clk(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_16);
        while (clk_cpu !== level) begin
            if (cycles >= 4 * PHASES) begin
                report_failure($sformatf("CPU clock never reached level %0d", level));
            end
            @(negedge clk_16);
            cycles++;
        end
    endtask

    // One host transaction, held until the done pulse
    task automatic host_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic rw_n, input logic [DATA_W-1:0] exp);
        int cycles;
        pi_req.addr  = addr;
        pi_req.wdata = wdata;
        pi_req.rw_n  = rw_n;
        pi_valid     = 1'b1;
        @(negedge clk_16);
        cycles = 1;
        while (pi_done !== 1'b1) begin
            if (cycles >= 4 * PHASES) begin
                report_failure("pi_done_o never arrived for the host request");
            end
            @(negedge clk_16);
            cycles++;
        end
        if (cycles < PI_LAST + 1 || cycles > PHASES + PI_LAST) begin
            report_failure($sformatf("host request took %0d cycles to finish", cycles));
        end
        check_addr("ram_addr_o (host)", ram_addr, addr);    // Host keeps the full address
        if (rw_n) begin
            check_data("pi_rdata_o", pi_rdata, exp);
        end
        pi_valid = 1'b0;                            // Drop before the next phase 0
        @(negedge clk_16);
        if (pi_done !== 1'b0) begin
            report_failure("pi_done_o stayed high longer than one cycle");
        end
        if (rw_n) begin
            check_data("pi_rdata_o (held)", pi_rdata, exp);
        end else begin
            check_ctl("{cpu_ready_o, cpu_res_nao}", {cpu_ready, cpu_res_n}, exp[1:0]);
        end
    endtask

    // One CPU cycle, inputs set up while the CPU clock is low
    task automatic cpu_access(input logic [15:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic rw_n, output cs_set_t cs,
                              output logic [DATA_W-1:0] rdata, output logic [ADDR_W-1:0] seen);
        int   cycles;
        logic we_seen;
        wait_cpu_clk(1'b0);
        cpu_addr = addr;
        cpu_data = wdata;
        cpu_rw_n = rw_n;
        wait_cpu_clk(1'b1);                         // Now in phase 8
        cs      = sample_cs();
        rdata   = cpu_rdata;
        seen    = ram_addr;
        we_seen = 1'b0;
        cycles  = 0;
        while (clk_cpu === 1'b1) begin
            if (!ram_we_n) begin
                we_seen = 1'b1;
            end
            if (cycles >= 4 * PHASES) begin
                report_failure("CPU clock never went low after the CPU window");
            end
            @(negedge clk_16);
            cycles++;
        end
        if (cycles != PHASES - CPU_FIRST) begin
            report_failure($sformatf("clk_cpu_o stayed high for %0d cycles instead of %0d",
                                     cycles, PHASES - CPU_FIRST));
        end
        cs.ram_we_n = !we_seen;
        cpu_addr    = 16'h0000;                     // Idle read of RAM
        cpu_data    = '0;
        cpu_rw_n    = 1'b1;
    endtask

    initial begin
        int                fd;
        int                code;
        int                n;
        int                line_no;
        int                n_tests;
        string             line;
        string             kind;
        logic [31:0]       f_addr;
        logic [31:0]       f_data;
        logic [31:0]       f_exp;
        cs_set_t           cs;
        logic [DATA_W-1:0] rdata;
        logic [ADDR_W-1:0] seen;
        arst_n   = 1'b0;
        pi_valid = 1'b0;
        pi_req   = '0;
        cpu_addr = 16'h0000;
        cpu_data = '0;
        cpu_rw_n = 1'b1;
        line_no  = 0;
        n_tests  = 0;
        fd = $fopen("test/pet_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open test/pet_tests.txt");
        end
        repeat (2) @(negedge clk_16);
        arst_n = 1'b1;
        if (pi_done !== 1'b0) begin
            report_failure("pi_done_o is high right after reset");
        end
        check_ctl("{cpu_ready_o, cpu_res_nao}", {cpu_ready, cpu_res_n}, 2'b00);
        check_region("chip selects after reset", sample_cs(), 6'h3F);
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            if (code == 0) begin
                break;
            end
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;                           // Column notes
            end
            n = $sscanf(line, "%s %h %h %h", kind, f_addr, f_data, f_exp);
            if (n <= 0) begin
                continue;                           // Blank line
            end
            if (n != 4) begin
                report_failure($sformatf("test file line %0d is malformed", line_no));
            end
            n_tests++;
            if (kind == "PW") begin
                host_access(f_addr[ADDR_W-1:0], f_data[DATA_W-1:0], 1'b0, f_exp[DATA_W-1:0]);
            end else if (kind == "PR") begin
                host_access(f_addr[ADDR_W-1:0], f_data[DATA_W-1:0], 1'b1, f_exp[DATA_W-1:0]);
            end else if (kind == "CW" || kind == "CS") begin
                cpu_access(f_addr[15:0], f_data[DATA_W-1:0], kind == "CS", cs, rdata, seen);
                check_addr("ram_addr_o (CPU)", seen, cpu_ram_addr(f_addr[15:0]));
                check_region("{ram_ce,ram_we,pia1,pia2,via,io_oe}_n", cs, f_exp[5:0]);
            end else if (kind == "CR") begin
                cpu_access(f_addr[15:0], f_data[DATA_W-1:0], 1'b1, cs, rdata, seen);
                check_addr("ram_addr_o (CPU)", seen, cpu_ram_addr(f_addr[15:0]));
                check_data("cpu_rdata_o", rdata, f_exp[DATA_W-1:0]);
            end else begin
                report_failure($sformatf("unknown kind %s on test file line %0d", kind, line_no));
            end
        end
        $fclose(fd);
        if (n_tests > 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure("the test file holds no transactions");
        end
    end

endmodule

//--- src/pet_main.sv
//######################################################################
// PET bus controller top level
//######################################################################
`timescale 1ns/1ps

module pet_main import pet_pkg::*; (
    input  logic              clk_16_i,             // 16 MHz main clock
    input  logic              arst_n_i,
    input  logic              pi_valid_i,
    input  pi_req_t           pi_req_i,
    output logic              pi_done_o,
    output logic [DATA_W-1:0] pi_rdata_o,
    output logic              clk_cpu_o,            // 1 MHz CPU clock
    output logic              cpu_res_nao,
    output logic              cpu_ready_o,
    input  logic [15:0]       cpu_addr_i,
    input  logic [DATA_W-1:0] cpu_data_i,
    input  logic              cpu_rw_n_i,
    output logic [DATA_W-1:0] cpu_rdata_o,
    input  logic [DATA_W-1:0] ram_data_i,
    output logic [ADDR_W-1:0] ram_addr_o,
    output logic [DATA_W-1:0] ram_data_o,
    output logic              ram_ce_no,
    output logic              ram_oe_no,
    output logic              ram_we_no,
    output logic              pia1_cs_no,
    output logic              pia2_cs_no,
    output logic              via_cs_no,
    output logic              io_oe_no
);
    bus_slot_t         slot;
    decode_t           dec;
    logic [ADDR_W-1:0] dec_addr;
    logic              kbd_enable;
    logic [DATA_W-1:0] kbd_data;
    logic [1:0]        ctl_rdata;

    bus_timing u_bus_timing (
        .clk_16_i, .arst_n_i, .pi_valid_i,
        .cpu_ready_i (cpu_ready_o),
        .clk_cpu_o,
        .slot_o      (slot)
    );

    address_decoder u_address_decoder (
        .addr_i (dec_addr),
        .dec_o  (dec)
    );

    keyboard_matrix u_keyboard_matrix (
        .clk_16_i, .arst_n_i,
        .slot_i       (slot),
        .pi_req_i, .cpu_addr_i, .cpu_data_i, .cpu_rw_n_i,
        .kbd_enable_o (kbd_enable),
        .kbd_data_o   (kbd_data)
    );

    pi_control u_pi_control (
        .clk_16_i, .arst_n_i,
        .slot_i      (slot),
        .pi_req_i, .cpu_res_nao, .cpu_ready_o,
        .ctl_rdata_o (ctl_rdata)
    );

    bus_mux u_bus_mux (
        .clk_16_i, .arst_n_i,
        .slot_i       (slot),
        .pi_req_i, .pi_done_o, .pi_rdata_o,
        .cpu_addr_i, .cpu_data_i, .cpu_rw_n_i,
        .cpu_ready_i  (cpu_ready_o),
        .dec_i        (dec),
        .kbd_enable_i (kbd_enable),
        .kbd_data_i   (kbd_data),
        .ctl_rdata_i  (ctl_rdata),
        .dec_addr_o   (dec_addr),
        .ram_data_i, .ram_addr_o, .ram_data_o, .ram_ce_no, .ram_oe_no, .ram_we_no,
        .pia1_cs_no, .pia2_cs_no, .via_cs_no, .io_oe_no, .cpu_rdata_o
    );

endmodule

//--- src/bus_mux.sv
//######################################################################
// Bus owner select, RAM strobes and chip selects
// Host read capture and CPU read return path
//######################################################################
`timescale 1ns/1ps

module bus_mux import pet_pkg::*; (
    input  logic              clk_16_i,
    input  logic              arst_n_i,
    input  bus_slot_t         slot_i,
    input  pi_req_t           pi_req_i,
    output logic              pi_done_o,
    output logic [DATA_W-1:0] pi_rdata_o,
    input  logic [15:0]       cpu_addr_i,
    input  logic [DATA_W-1:0] cpu_data_i,
    input  logic              cpu_rw_n_i,
    input  logic              cpu_ready_i,
    input  decode_t           dec_i,
    input  logic              kbd_enable_i,
    input  logic [DATA_W-1:0] kbd_data_i,
    input  logic [1:0]        ctl_rdata_i,
    output logic [ADDR_W-1:0] dec_addr_o,
    input  logic [DATA_W-1:0] ram_data_i,
    output logic [ADDR_W-1:0] ram_addr_o,
    output logic [DATA_W-1:0] ram_data_o,
    output logic              ram_ce_no,
    output logic              ram_oe_no,
    output logic              ram_we_no,
    output logic              pia1_cs_no,
    output logic              pia2_cs_no,
    output logic              via_cs_no,
    output logic              io_oe_no,
    output logic [DATA_W-1:0] cpu_rdata_o
);
    logic              pi_sel;
    logic              cpu_en;
    logic              rd;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] pi_live;
    logic [DATA_W-1:0] pi_rdata_q;

    assign pi_sel   = (slot_i.owner == OWNER_PI);
    assign cpu_en   = (slot_i.owner == OWNER_CPU) && cpu_ready_i;
    assign cpu_addr = {1'b0, cpu_addr_i};

    assign dec_addr_o = pi_sel ? pi_req_i.addr : cpu_addr;

    // VRAM is 1K mirrored across 8000-8FFF for the CPU only
    always_comb begin
        ram_addr_o = dec_addr_o;
        if (!pi_sel && dec_i.is_mirrored) begin
            ram_addr_o[11:10] = 2'b00;
        end
    end

    assign ram_data_o = pi_sel ? pi_req_i.wdata : cpu_data_i;
    assign rd         = pi_sel ? pi_req_i.rw_n : cpu_rw_n_i;

    assign ram_ce_no = !(dec_i.ram_enable && (pi_sel || cpu_en));
    assign ram_oe_no = !(dec_i.ram_enable && (pi_sel || cpu_en) && rd);
    assign ram_we_no = !(dec_i.ram_enable &&
                         ((pi_sel && !pi_req_i.rw_n && slot_i.pi_write_strobe) ||
                          (cpu_en && !cpu_rw_n_i && slot_i.cpu_write_strobe &&
                           !dec_i.is_readonly)));

    assign pia1_cs_no = !(cpu_en && dec_i.pia1 && !kbd_enable_i);   // PIA1 masked on intercept
    assign pia2_cs_no = !(cpu_en && dec_i.pia2);
    assign via_cs_no  = !(cpu_en && dec_i.via);
    assign io_oe_no   = !(cpu_en && dec_i.io_enable && !kbd_enable_i);

    assign pi_live = (pi_req_i.addr == {1'b0, CTL_ADDR}) ? {6'b0, ctl_rdata_i} : ram_data_i;

    always_ff @(posedge clk_16_i) begin
        if (slot_i.pi_strobe) begin
            pi_rdata_q <= pi_live;                  // Held until the next done
        end
    end

    assign pi_done_o   = slot_i.pi_strobe;
    assign pi_rdata_o  = slot_i.pi_strobe ? pi_live : pi_rdata_q;
    assign cpu_rdata_o = kbd_enable_i ? kbd_data_i : ram_data_i;

    // RAM output stays off during a write pulse and one phase after it
    a_we_oe_turnaround: assert property (@(posedge clk_16_i) disable iff (!arst_n_i)
        !ram_we_no |-> ram_oe_no ##1 ram_oe_no);

endmodule

//--- src/pi_control.sv
//######################################################################
// Host control register for CPU reset and ready
//######################################################################
`timescale 1ns/1ps

module pi_control import pet_pkg::*; (
    input  logic       clk_16_i,
    input  logic       arst_n_i,
    input  bus_slot_t  slot_i,
    input  pi_req_t    pi_req_i,
    output logic       cpu_res_nao,                 // 0 = CPU held in reset
    output logic       cpu_ready_o,                 // 0 = halt, 1 = run
    output logic [1:0] ctl_rdata_o
);
    logic [1:0] ctl_q;                              // Bit 0 run, bit 1 ready
    logic       ctl_wr;

    assign ctl_wr = slot_i.pi_strobe && !pi_req_i.rw_n &&
                    (pi_req_i.addr == {1'b0, CTL_ADDR});

    always_ff @(posedge clk_16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_q <= 2'b00;                         // CPU in reset and halted
        end else if (ctl_wr) begin
            ctl_q <= pi_req_i.wdata[1:0];
        end
    end

    assign cpu_res_nao = ctl_q[0];
    assign cpu_ready_o = ctl_q[1];
    assign ctl_rdata_o = ctl_q;

endmodule

//--- src/keyboard_matrix.sv
//######################################################################
// Keyboard matrix filled by the host
// Row select latch and PIA1 port B read intercept
//######################################################################
`timescale 1ns/1ps

module keyboard_matrix import pet_pkg::*; (
    input  logic              clk_16_i,
    input  logic              arst_n_i,
    input  bus_slot_t         slot_i,
    input  pi_req_t           pi_req_i,
    input  logic [15:0]       cpu_addr_i,
    input  logic [DATA_W-1:0] cpu_data_i,
    input  logic              cpu_rw_n_i,
    output logic              kbd_enable_o,         // Replaces PIA1 on the read
    output logic [DATA_W-1:0] kbd_data_o
);
    logic [DATA_W-1:0] rows_q [KBD_ROWS];           // Active low, 0 = key down
    logic [3:0]        row_sel_q;
    logic              pi_row_wr;
    logic              cpu_sel_wr;
    logic              cpu_slot;

    assign cpu_slot  = (slot_i.owner == OWNER_CPU);

    assign pi_row_wr = slot_i.pi_strobe && !pi_req_i.rw_n && !pi_req_i.addr[16] &&
                       (pi_req_i.addr[15:4] == KBD_PI_BASE[15:4]) &&
                       (pi_req_i.addr[3:0] < KBD_ROWS);

    assign cpu_sel_wr = cpu_slot && slot_i.cpu_end && !cpu_rw_n_i &&
                        (cpu_addr_i == PIA1_PORTA);

    always_ff @(posedge clk_16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < KBD_ROWS; r++) begin
                rows_q[r] <= '1;                    // No keys pressed
            end
            row_sel_q <= '0;
        end else begin
            if (pi_row_wr) begin
                rows_q[pi_req_i.addr[3:0]] <= pi_req_i.wdata;
            end
            if (cpu_sel_wr) begin
                row_sel_q <= cpu_data_i[3:0];       // Low nibble picks the row
            end
        end
    end

    assign kbd_enable_o = cpu_slot && cpu_rw_n_i && (cpu_addr_i == PIA1_PORTB);
    assign kbd_data_o   = (row_sel_q < KBD_ROWS) ? rows_q[row_sel_q] : '1;

endmodule

//--- src/address_decoder.sv
//######################################################################
// PET memory map decode into region and attribute flags
//######################################################################
`timescale 1ns/1ps

module address_decoder import pet_pkg::*; (
    input  logic [ADDR_W-1:0] addr_i,
    output decode_t           dec_o
);
    logic [15:0] a;

    assign a = addr_i[15:0];

    always_comb begin
        dec_o        = '0;
        dec_o.region = REG_HOLE;
        if (addr_i[16]) begin
            dec_o.region     = REG_RAM;             // Upper 64K, host-only RAM
            dec_o.ram_enable = 1'b1;
        end else if (a < VRAM_BASE) begin
            dec_o.region     = REG_RAM;
            dec_o.ram_enable = 1'b1;
        end else if (a <= VRAM_END) begin
            dec_o.region      = REG_VRAM;
            dec_o.ram_enable  = 1'b1;
            dec_o.is_mirrored = 1'b1;
        end else if (a >= IO_BASE && a <= IO_END) begin
            dec_o.io_enable = 1'b1;                 // I/O page, RAM off
            if (a[15:4] == PIA1_PORTA[15:4]) begin
                dec_o.region = REG_PIA1;            // E810-E81F
                dec_o.pia1   = 1'b1;
            end else if (a[15:4] == PIA2_BASE[15:4]) begin
                dec_o.region = REG_PIA2;            // E820-E82F
                dec_o.pia2   = 1'b1;
            end else if (a[15:6] == VIA_BASE[15:6]) begin
                dec_o.region = REG_VIA;             // E840-E87F
                dec_o.via    = 1'b1;
            end else begin
                dec_o.region = REG_IO_OTHER;
            end
        end else if (a >= ROM_BASE) begin
            dec_o.region      = REG_ROM;            // Shadowed ROM lives in RAM
            dec_o.ram_enable  = 1'b1;
            dec_o.is_readonly = 1'b1;
        end
    end

endmodule

//--- src/bus_timing.sv
//######################################################################
// Phase counter, CPU clock and bus slot ownership
//######################################################################
`timescale 1ns/1ps

module bus_timing import pet_pkg::*; (
    input  logic      clk_16_i,
    input  logic      arst_n_i,
    input  logic      pi_valid_i,                   // Host request pending
    input  logic      cpu_ready_i,
    output logic      clk_cpu_o,                    // 1 MHz CPU clock
    output bus_slot_t slot_o
);
    logic [PHASE_W-1:0] phase_q;
    logic               pi_owned_q;                 // Host takes phases 0..3 this cycle
    logic               cpu_owned_q;                // CPU runs phases 8..15 this cycle
    logic               in_pi_win;
    logic               in_cpu_win;

    always_ff @(posedge clk_16_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q     <= '0;
            pi_owned_q  <= 1'b0;
            cpu_owned_q <= 1'b0;
        end else begin
            phase_q <= phase_q + 1'b1;              // Wraps at PHASES
            if (phase_q == PHASE_LAST) begin
                pi_owned_q <= pi_valid_i;           // Sampled on the edge into phase 0
            end
            if (phase_q == CPU_FIRST - 1'b1) begin
                cpu_owned_q <= cpu_ready_i;         // Held for the whole CPU window
            end
        end
    end

    assign in_pi_win  = (phase_q >= PI_FIRST) && (phase_q <= PI_LAST);
    assign in_cpu_win = (phase_q >= CPU_FIRST);
    assign clk_cpu_o  = in_cpu_win;                 // High in phases 8..15

    always_comb begin
        slot_o       = '0;
        slot_o.owner = OWNER_NONE;                  // Phases 4..7 always idle
        if (in_pi_win && pi_owned_q) begin
            slot_o.owner = OWNER_PI;
        end else if (in_cpu_win && cpu_owned_q) begin
            slot_o.owner = OWNER_CPU;
        end
        slot_o.pi_write_strobe  = pi_owned_q && (phase_q > PI_FIRST) && (phase_q < PI_LAST);
        slot_o.pi_strobe        = pi_owned_q && (phase_q == PI_LAST);
        slot_o.cpu_write_strobe = cpu_owned_q && in_cpu_win &&
                                  (phase_q >= CPU_WE_FIRST) && (phase_q <= CPU_WE_LAST);
        slot_o.cpu_end          = (phase_q == PHASE_LAST);
    end

    // Done strobe closes a host window held since phase 0
    a_pi_window_held: assert property (@(posedge clk_16_i) disable iff (!arst_n_i)
        slot_o.pi_strobe |-> $past(slot_o.owner == OWNER_PI, PI_LAST - PI_FIRST));

endmodule

//--- src/pet_pkg.sv
//######################################################################
// Shared definitions for the PET bus controller
// Memory map, phase numbers, bus enums and packed bus structs
//######################################################################
package pet_pkg;

    localparam int ADDR_W   = 17;                       // Bus address incl. host-only bit 16
    localparam int DATA_W   = 8;
    localparam int PHASES   = 16;                       // 16 MHz ticks per 1 MHz CPU cycle
    localparam int PHASE_W  = $clog2(PHASES);
    localparam int KBD_ROWS = 10;

    // Phase numbers within one CPU cycle
    localparam logic [PHASE_W-1:0] PI_FIRST     = 4'd0;
    localparam logic [PHASE_W-1:0] PI_LAST      = 4'd3;   // Host done and capture phase
    localparam logic [PHASE_W-1:0] CPU_FIRST    = 4'd8;   // CPU clock high from here
    localparam logic [PHASE_W-1:0] CPU_WE_FIRST = 4'd12;
    localparam logic [PHASE_W-1:0] CPU_WE_LAST  = 4'd14;
    localparam logic [PHASE_W-1:0] PHASE_LAST   = PHASE_W'(PHASES - 1);

    // PET memory map, 16-bit CPU view
    localparam logic [15:0] VRAM_BASE   = 16'h8000;
    localparam logic [15:0] VRAM_END    = 16'h8FFF;
    localparam logic [15:0] ROM_BASE    = 16'h9000;
    localparam logic [15:0] IO_BASE     = 16'hE800;
    localparam logic [15:0] IO_END      = 16'hE8FF;
    localparam logic [15:0] PIA1_PORTA  = 16'hE810;   // Keyboard row select
    localparam logic [15:0] PIA1_PORTB  = 16'hE812;   // Keyboard column read
    localparam logic [15:0] PIA2_BASE   = 16'hE820;
    localparam logic [15:0] VIA_BASE    = 16'hE840;
    localparam logic [15:0] KBD_PI_BASE = 16'hE800;   // Host writes rows 0..9 here
    localparam logic [15:0] CTL_ADDR    = 16'hE80F;   // Host control register

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_PI,
        OWNER_CPU
    } bus_owner_e;

    typedef enum logic [2:0] {
        REG_RAM,
        REG_VRAM,
        REG_ROM,
        REG_PIA1,
        REG_PIA2,
        REG_VIA,
        REG_IO_OTHER,
        REG_HOLE
    } region_e;

    typedef struct packed {
        region_e region;
        logic    ram_enable;
        logic    io_enable;
        logic    pia1;
        logic    pia2;
        logic    via;
        logic    is_readonly;                       // ROM, CPU writes dropped
        logic    is_mirrored;                       // VRAM, A11/A10 forced low for CPU
    } decode_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              rw_n;                    // 1 = read
    } pi_req_t;

    typedef struct packed {
        bus_owner_e owner;
        logic       pi_write_strobe;                // Host phases 1..2
        logic       pi_strobe;                      // Last host phase
        logic       cpu_write_strobe;               // CPU phases 12..14
        logic       cpu_end;                        // Phase 15
    } bus_slot_t;

endpackage
